// ==== logic/icache_params.svh ====
//----------------------------
// icache front end macros
// TQ depth, line geometry, field widths and address bit positions
//----------------------------
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

`define ICACHE_NUM_TQ_ENTRY 4
`define ICACHE_WORDS_IN_CL  4
`define ICACHE_NUM_SETS     16
`define ICACHE_ADDR_W       32
`define ICACHE_REG_ID_W     5
`define ICACHE_WORD_W       32

// derived field widths
`define ICACHE_TQ_ID_W      $clog2(`ICACHE_NUM_TQ_ENTRY)
`define ICACHE_WORD_OFF_W   $clog2(`ICACHE_WORDS_IN_CL)
`define ICACHE_SET_W        $clog2(`ICACHE_NUM_SETS)
`define ICACHE_WORD_OFF_LSB 2
`define ICACHE_SET_LSB      (`ICACHE_WORD_OFF_LSB + `ICACHE_WORD_OFF_W)
`define ICACHE_TAG_W        (`ICACHE_ADDR_W - `ICACHE_SET_LSB - `ICACHE_SET_W)
`define ICACHE_CL_ADDR_W    (`ICACHE_TAG_W + `ICACHE_SET_W)

`endif

// ==== logic/icache_pkg.sv ====
//----------------------------
// shared types of the icache front end
// address fields, TQ entry state, lookup op and lookup result
//----------------------------
`default_nettype none

`include "icache_params.svh"

package icache_pkg;

//----------------------------
// vectors
//----------------------------
typedef logic [`ICACHE_ADDR_W-1:0]                        t_address;
typedef logic [`ICACHE_WORD_W-1:0]                        t_word;
typedef logic [`ICACHE_WORDS_IN_CL*`ICACHE_WORD_W-1:0]    t_cl;
typedef logic [`ICACHE_WORD_OFF_W-1:0]                    t_word_offset;
typedef logic [`ICACHE_SET_W-1:0]                         t_set;
typedef logic [`ICACHE_TAG_W-1:0]                         t_tag;
typedef logic [`ICACHE_CL_ADDR_W-1:0]                     t_cl_address; // tag and set
typedef logic [`ICACHE_REG_ID_W-1:0]                      t_reg_id;
typedef logic [`ICACHE_TQ_ID_W-1:0]                       t_tq_id;

//----------------------------
// enums
//----------------------------
typedef enum logic [1:0] {
    s_idle,
    s_lu_core,          // lookup in flight
    s_mb_wait_fill,     // FM read outstanding
    s_mb_fill_ready     // line buffered, waiting for a pipe slot
} t_tq_state;

typedef enum logic [1:0] {
    no_lu,
    rd_lu,
    fill_lu
} t_lu_op;

typedef enum logic [1:0] {
    hit,
    miss,
    fill
} t_lu_result;

endpackage

`default_nettype wire

// ==== logic/icache_req_decode.sv ====
//----------------------------
// request decode
// reissue buffer, read miss stall, ready
// q1 lookup mux between core, reissue and fill
//----------------------------
`timescale 1ns/10ps
`default_nettype none

`include "icache_params.svh"

module icache_req_decode
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         req_valid,
    input  t_address     req_address,
    input  t_reg_id      req_reg_id,
    output logic         ready,
    input  logic         early_rd_miss,
    input  logic         early_fill_valid,
    input  t_tq_id       early_tq_id,
    input  t_cl_address  early_cl_address,
    input  logic         tq_full,
    input  t_tq_id       free_tq_id,
    input  logic         fill_exists,
    input  t_tq_id       fill_tq_id,
    input  t_cl_address  fill_cl_address,
    input  t_word_offset fill_word_offset,
    input  t_reg_id      fill_reg_id,
    input  t_cl          fill_cl_data,
    output logic         req_pending,
    output logic         alloc_valid,
    output t_cl_address  alloc_cl_address,
    output t_word_offset alloc_word_offset,
    output t_reg_id      alloc_reg_id,
    output logic         lu_req_valid,
    output t_lu_op       lu_req_op,
    output t_address     lu_req_address,
    output t_reg_id      lu_req_reg_id,
    output t_tq_id       lu_req_tq_id,
    output t_cl          lu_req_cl_data
);

logic        stall_rd_miss_q;
logic        rd_miss_was_filled;
logic        set_was_filled;
logic        sel_reissue;
logic        reissue_valid;
t_address    reissue_address;
t_reg_id     reissue_reg_id;
t_tq_id      rd_miss_tq_id;
t_cl_address rd_miss_cl_address;
logic        cur_valid;
t_address    cur_address;
t_reg_id     cur_reg_id;

//----------------------------
// reissue buffer
//----------------------------
// the q1 request is cancelled by a q2 miss, keep it and the missing line
always_ff @(posedge clk) begin
    if (early_rd_miss) begin
        reissue_address    <= req_address;
        reissue_reg_id     <= req_reg_id;
        rd_miss_tq_id      <= early_tq_id;
        rd_miss_cl_address <= early_cl_address;
    end
end

assign set_was_filled = stall_rd_miss_q && early_fill_valid &&
                        (early_tq_id == rd_miss_tq_id) &&
                        (early_cl_address == rd_miss_cl_address);

always_ff @(posedge clk) begin
    if (reset) begin
        reissue_valid      <= 1'b0;
        stall_rd_miss_q    <= 1'b0;
        rd_miss_was_filled <= 1'b0;
    end else begin
        if (early_rd_miss)
            reissue_valid <= req_valid;     // may be an empty slot
        if (sel_reissue)
            stall_rd_miss_q <= 1'b0;
        else if (early_rd_miss)
            stall_rd_miss_q <= 1'b1;
        if (sel_reissue)
            rd_miss_was_filled <= 1'b0;
        else if (set_was_filled)
            rd_miss_was_filled <= 1'b1;
    end
end

// let any waiting fill go first, the reissue follows
assign sel_reissue = rd_miss_was_filled && !fill_exists;
assign cur_valid   = sel_reissue ? reissue_valid   : req_valid;
assign cur_address = sel_reissue ? reissue_address : req_address;
assign cur_reg_id  = sel_reissue ? reissue_reg_id  : req_reg_id;

assign ready       = !(tq_full || stall_rd_miss_q || early_rd_miss);
assign req_pending = cur_valid;                     // blocks the fill even when cancelled

assign alloc_valid       = cur_valid && !early_rd_miss;
assign alloc_cl_address  = cur_address[`ICACHE_ADDR_W-1 -: `ICACHE_CL_ADDR_W];
assign alloc_word_offset = cur_address[`ICACHE_WORD_OFF_LSB +: `ICACHE_WORD_OFF_W];
assign alloc_reg_id      = cur_reg_id;

//----------------------------
// q1 lookup mux
//----------------------------
always_comb begin
    lu_req_valid   = 1'b0;
    lu_req_op      = no_lu;
    lu_req_address = cur_address;
    lu_req_reg_id  = cur_reg_id;
    lu_req_tq_id   = free_tq_id;
    lu_req_cl_data = '0;
    if (cur_valid) begin
        if (!early_rd_miss) begin
            lu_req_valid = 1'b1;
            lu_req_op    = rd_lu;
        end
    end else if (fill_exists) begin
        lu_req_valid   = 1'b1;
        lu_req_op      = fill_lu;
        lu_req_address = {fill_cl_address, fill_word_offset, 2'b00};
        lu_req_reg_id  = fill_reg_id;
        lu_req_tq_id   = fill_tq_id;
        lu_req_cl_data = fill_cl_data;
    end
end

endmodule

`default_nettype wire

// ==== logic/icache_tq.sv ====
//----------------------------
// transaction queue
// per entry FSM and fields, first free and first fill select
// FM read request issue
//----------------------------
`timescale 1ns/10ps
`default_nettype none

`include "icache_params.svh"

module icache_tq
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         alloc_valid,
    input  t_cl_address  alloc_cl_address,
    input  t_word_offset alloc_word_offset,
    input  t_reg_id      alloc_reg_id,
    input  logic         lu_rsp_valid,
    input  t_lu_result   lu_rsp_result,
    input  t_tq_id       lu_rsp_tq_id,
    input  logic         fm_rd_rsp_valid,
    input  t_cl_address  fm_rd_rsp_cl_address,
    input  t_cl          fm_rd_rsp_data,
    input  logic         req_pending,
    output t_tq_id       free_tq_id,
    output logic         tq_full,
    output logic         fill_exists,
    output t_tq_id       fill_tq_id,
    output t_cl_address  fill_cl_address,
    output t_word_offset fill_word_offset,
    output t_reg_id      fill_reg_id,
    output t_cl          fill_cl_data,
    output logic         fm_rd_req_valid,
    output t_cl_address  fm_rd_req_cl_address
);

t_tq_state    tq_state      [`ICACHE_NUM_TQ_ENTRY];
t_tq_state    next_tq_state [`ICACHE_NUM_TQ_ENTRY];
t_cl_address  tq_cl_address [`ICACHE_NUM_TQ_ENTRY];
t_word_offset tq_word_offset[`ICACHE_NUM_TQ_ENTRY];
t_reg_id      tq_reg_id     [`ICACHE_NUM_TQ_ENTRY];
t_cl          tq_line       [`ICACHE_NUM_TQ_ENTRY];

logic [`ICACHE_NUM_TQ_ENTRY-1:0] alloc_entry;
logic [`ICACHE_NUM_TQ_ENTRY-1:0] load_line;
logic [`ICACHE_TQ_ID_W:0]        idle_count;
logic                            free_exists;

//----------------------------
// entry select
//----------------------------
// walk downwards so the lowest index wins
always_comb begin
    free_exists = 1'b0;
    free_tq_id  = '0;
    fill_exists = 1'b0;
    fill_tq_id  = '0;
    idle_count  = '0;
    for (int i = `ICACHE_NUM_TQ_ENTRY-1; i >= 0; i--) begin
        if (tq_state[i] == s_idle) begin
            free_exists = 1'b1;
            free_tq_id  = t_tq_id'(i);
            idle_count  = idle_count + 1'b1;
        end
        if (tq_state[i] == s_mb_fill_ready) begin
            fill_exists = 1'b1;
            fill_tq_id  = t_tq_id'(i);
        end
    end
end

// one entry stays spare for the request cancelled behind a miss
assign tq_full = (idle_count <= 1);

//----------------------------
// entry FSMs
//----------------------------
always_comb begin
    for (int i = 0; i < `ICACHE_NUM_TQ_ENTRY; i++) begin
        next_tq_state[i] = tq_state[i];
        alloc_entry[i]   = alloc_valid && free_exists && (free_tq_id == t_tq_id'(i));
        load_line[i]     = 1'b0;
        unique case (tq_state[i])
            s_idle: begin
                if (alloc_entry[i])
                    next_tq_state[i] = s_lu_core;
            end
            s_lu_core: begin
                if (lu_rsp_valid && (lu_rsp_tq_id == t_tq_id'(i))) begin
                    if (lu_rsp_result == hit)
                        next_tq_state[i] = s_idle;
                    else if (lu_rsp_result == miss)
                        next_tq_state[i] = s_mb_wait_fill;
                    // a fill result here is left over from the previous owner
                end
            end
            s_mb_wait_fill: begin
                if (fm_rd_rsp_valid && (fm_rd_rsp_cl_address == tq_cl_address[i])) begin
                    next_tq_state[i] = s_mb_fill_ready;
                    load_line[i]     = 1'b1;
                end
            end
            s_mb_fill_ready: begin
                if ((fill_tq_id == t_tq_id'(i)) && !req_pending)   // pipe slot taken
                    next_tq_state[i] = s_idle;
            end
            default: begin
                next_tq_state[i] = s_idle;
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    for (int i = 0; i < `ICACHE_NUM_TQ_ENTRY; i++) begin
        if (reset)
            tq_state[i] <= s_idle;
        else
            tq_state[i] <= next_tq_state[i];
        if (alloc_entry[i]) begin
            tq_cl_address[i]  <= alloc_cl_address;
            tq_word_offset[i] <= alloc_word_offset;
            tq_reg_id[i]      <= alloc_reg_id;
        end
        if (load_line[i])
            tq_line[i] <= fm_rd_rsp_data;
    end
end

assign fill_cl_address  = tq_cl_address[fill_tq_id];
assign fill_word_offset = tq_word_offset[fill_tq_id];
assign fill_reg_id      = tq_reg_id[fill_tq_id];
assign fill_cl_data     = tq_line[fill_tq_id];

//----------------------------
// FM read request
//----------------------------
always_ff @(posedge clk) begin
    if (reset)
        fm_rd_req_valid <= 1'b0;
    else
        fm_rd_req_valid <= lu_rsp_valid && (lu_rsp_result == miss);
    fm_rd_req_cl_address <= tq_cl_address[lu_rsp_tq_id];
end

endmodule

`default_nettype wire

// ==== logic/icache_lookup_pipe.sv ====
//----------------------------
// lookup pipe
// tag, valid and line arrays, q1 to q3 stages
// early miss and fill report at q2, lookup response at q3
//----------------------------
`timescale 1ns/10ps
`default_nettype none

`include "icache_params.svh"

module icache_lookup_pipe
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        lu_req_valid,
    input  t_lu_op      lu_req_op,
    input  t_address    lu_req_address,
    input  t_reg_id     lu_req_reg_id,
    input  t_tq_id      lu_req_tq_id,
    input  t_cl         lu_req_cl_data,
    output logic        early_rd_miss,
    output logic        early_fill_valid,
    output t_tq_id      early_tq_id,
    output t_cl_address early_cl_address,
    output logic        lu_rsp_valid,
    output t_lu_op      lu_rsp_op,
    output t_lu_result  lu_rsp_result,
    output t_tq_id      lu_rsp_tq_id,
    output t_address    lu_rsp_address,
    output t_reg_id     lu_rsp_reg_id,
    output t_cl         lu_rsp_cl_data
);

logic [`ICACHE_NUM_SETS-1:0] set_valid;
t_tag                        set_tag [`ICACHE_NUM_SETS];
t_cl                         set_line[`ICACHE_NUM_SETS];

logic       wr_en;
t_set       wr_set;
t_tag       wr_tag;
t_set       req_set;
logic       fwd_q1;
logic       q2_valid;
t_lu_op     q2_op;
t_address   q2_address;
t_reg_id    q2_reg_id;
t_tq_id     q2_tq_id;
t_cl        q2_cl_data;         // fill payload, or the line read at q1
logic       q2_way_valid;
t_tag       q2_way_tag;
logic       fwd_q2;
logic       q2_hit;
t_cl        q2_line;
t_lu_result q2_result;

//----------------------------
// arrays, written by a fill at q3
//----------------------------
assign wr_en  = lu_rsp_valid && (lu_rsp_op == fill_lu);
assign wr_set = lu_rsp_address[`ICACHE_SET_LSB +: `ICACHE_SET_W];
assign wr_tag = lu_rsp_address[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

always_ff @(posedge clk) begin
    if (reset)
        set_valid <= '0;
    else if (wr_en)
        set_valid[wr_set] <= 1'b1;
    if (wr_en) begin
        set_tag[wr_set]  <= wr_tag;
        set_line[wr_set] <= lu_rsp_cl_data;
    end
end

//----------------------------
// q1, register request and read the set
//----------------------------
assign req_set = lu_req_address[`ICACHE_SET_LSB +: `ICACHE_SET_W];
assign fwd_q1  = wr_en && (wr_set == req_set);     // same edge as the write

always_ff @(posedge clk) begin
    if (reset)
        q2_valid <= 1'b0;
    else
        q2_valid <= lu_req_valid;
    q2_op        <= lu_req_op;
    q2_address   <= lu_req_address;
    q2_reg_id    <= lu_req_reg_id;
    q2_tq_id     <= lu_req_tq_id;
    q2_way_valid <= fwd_q1 || set_valid[req_set];
    q2_way_tag   <= fwd_q1 ? wr_tag : set_tag[req_set];
    if (lu_req_op == fill_lu)
        q2_cl_data <= lu_req_cl_data;
    else
        q2_cl_data <= fwd_q1 ? lu_rsp_cl_data : set_line[req_set];
end

//----------------------------
// q2, tag compare
//----------------------------
// a fill one slot ahead sits in q3 and is not written yet
assign fwd_q2 = wr_en && (wr_set == q2_address[`ICACHE_SET_LSB +: `ICACHE_SET_W]);
assign q2_hit = (fwd_q2 ? 1'b1 : q2_way_valid) &&
                ((fwd_q2 ? wr_tag : q2_way_tag) == q2_address[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W]);
assign q2_line   = (fwd_q2 && (q2_op == rd_lu)) ? lu_rsp_cl_data : q2_cl_data;
assign q2_result = (q2_op == fill_lu) ? fill : (q2_hit ? hit : miss);

assign early_rd_miss    = q2_valid && (q2_op == rd_lu) && !q2_hit;
assign early_fill_valid = q2_valid && (q2_op == fill_lu);
assign early_tq_id      = q2_tq_id;
assign early_cl_address = q2_address[`ICACHE_ADDR_W-1 -: `ICACHE_CL_ADDR_W];

//----------------------------
// q3, lookup response
//----------------------------
always_ff @(posedge clk) begin
    if (reset)
        lu_rsp_valid <= 1'b0;
    else
        lu_rsp_valid <= q2_valid;
    lu_rsp_op      <= q2_op;
    lu_rsp_result  <= q2_result;
    lu_rsp_tq_id   <= q2_tq_id;
    lu_rsp_address <= q2_address;
    lu_rsp_reg_id  <= q2_reg_id;
    lu_rsp_cl_data <= q2_line;
end

endmodule

`default_nettype wire

// ==== logic/icache_rsp_select.sv ====
//----------------------------
// core response
// valid decode, word select, registered output
//----------------------------
`timescale 1ns/10ps
`default_nettype none

`include "icache_params.svh"

module icache_rsp_select
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       lu_rsp_valid,
    input  t_lu_op     lu_rsp_op,
    input  t_lu_result lu_rsp_result,
    input  t_address   lu_rsp_address,
    input  t_reg_id    lu_rsp_reg_id,
    input  t_cl        lu_rsp_cl_data,
    output logic       rsp_valid,
    output t_address   rsp_address,
    output t_word      rsp_data,
    output t_reg_id    rsp_reg_id
);

logic         rsp_fire;
t_word_offset word_sel;

// every fill carries the read that missed
assign rsp_fire = lu_rsp_valid &&
                  (((lu_rsp_op == rd_lu) && (lu_rsp_result == hit)) || (lu_rsp_op == fill_lu));
assign word_sel = lu_rsp_address[`ICACHE_WORD_OFF_LSB +: `ICACHE_WORD_OFF_W];

always_ff @(posedge clk) begin
    if (reset)
        rsp_valid <= 1'b0;
    else
        rsp_valid <= rsp_fire;
    rsp_address <= lu_rsp_address;
    rsp_reg_id  <= lu_rsp_reg_id;
    rsp_data    <= lu_rsp_cl_data[word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];
end

endmodule

`default_nettype wire

// ==== logic/icache_top.sv ====
//----------------------------
// icache front end top
// decode, TQ, lookup pipe and response stage
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  t_address    req_address,
    input  t_reg_id     req_reg_id,
    output logic        ready,
    output logic        rsp_valid,
    output t_address    rsp_address,
    output t_word       rsp_data,
    output t_reg_id     rsp_reg_id,
    output logic        fm_rd_req_valid,
    output t_cl_address fm_rd_req_cl_address,
    input  logic        fm_rd_rsp_valid,
    input  t_cl_address fm_rd_rsp_cl_address,
    input  t_cl         fm_rd_rsp_data
);

// q1 request
logic         lu_req_valid;
t_lu_op       lu_req_op;
t_address     lu_req_address;
t_reg_id      lu_req_reg_id;
t_tq_id       lu_req_tq_id;
t_cl          lu_req_cl_data;
// q2 early report
logic         early_rd_miss;
logic         early_fill_valid;
t_tq_id       early_tq_id;
t_cl_address  early_cl_address;
// q3 response
logic         lu_rsp_valid;
t_lu_op       lu_rsp_op;
t_lu_result   lu_rsp_result;
t_tq_id       lu_rsp_tq_id;
t_address     lu_rsp_address;
t_reg_id      lu_rsp_reg_id;
t_cl          lu_rsp_cl_data;
// decode and TQ
logic         alloc_valid;
t_cl_address  alloc_cl_address;
t_word_offset alloc_word_offset;
t_reg_id      alloc_reg_id;
logic         req_pending;
t_tq_id       free_tq_id;
logic         tq_full;
logic         fill_exists;
t_tq_id       fill_tq_id;
t_cl_address  fill_cl_address;
t_word_offset fill_word_offset;
t_reg_id      fill_reg_id;
t_cl          fill_cl_data;

icache_req_decode  i_icache_req_decode  (.*);
icache_tq          i_icache_tq          (.*);
icache_lookup_pipe i_icache_lookup_pipe (.*);
icache_rsp_select  i_icache_rsp_select  (.*);

endmodule

`default_nettype wire

// ==== tb/icache_fm_model.sv ====
//----------------------------
// fill memory responder
// random latency, in order responses
// random backing lines created on first touch
//----------------------------
`timescale 1ns/10ps
`default_nettype none

`include "icache_params.svh"

module icache_fm_model
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        fm_rd_req_valid,
    input  t_cl_address fm_rd_req_cl_address,
    output logic        fm_rd_rsp_valid,
    output t_cl_address fm_rd_rsp_cl_address,
    output t_cl         fm_rd_rsp_data
);

localparam int min_latency = 2;
localparam int max_latency = 20;

t_cl         store   [t_cl_address];    // backing lines
t_cl_address pend_q  [$];
int unsigned due_q   [$];               // cycle at which each pending line may return
int unsigned cycle;
int unsigned last_due;
integer      seed;

// requests are taken between edges
always @(negedge clk) begin : capture_request
    int unsigned due;
    t_cl         line;
    if (!reset && fm_rd_req_valid) begin
        if (!store.exists(fm_rd_req_cl_address)) begin
            for (int w = 0; w < `ICACHE_WORDS_IN_CL; w++)
                line[w*`ICACHE_WORD_W +: `ICACHE_WORD_W] = $random(seed);
            store[fm_rd_req_cl_address] = line;
        end
        due = cycle + min_latency +
              ($unsigned($random(seed)) % (max_latency - min_latency + 1));
        if (due <= last_due)
            due = last_due + 1;             // keep request order
        last_due = due;
        pend_q.push_back(fm_rd_req_cl_address);
        due_q.push_back(due);
    end
end

//----------------------------
// response drive
//----------------------------
initial begin
    seed                 = 32'h605;
    cycle                = 0;
    last_due             = 0;
    fm_rd_rsp_valid      = 1'b0;
    fm_rd_rsp_cl_address = '0;
    fm_rd_rsp_data       = '0;
    forever begin
        @(posedge clk);
        cycle = cycle + 1;
        if (!reset && (due_q.size() > 0) && (due_q[0] <= cycle)) begin
            fm_rd_rsp_valid      <= 1'b1;
            fm_rd_rsp_cl_address <= pend_q[0];
            fm_rd_rsp_data       <= store[pend_q[0]];
            void'(pend_q.pop_front());
            void'(due_q.pop_front());
        end else begin
            fm_rd_rsp_valid <= 1'b0;         // one line per cycle at most
        end
    end
end

endmodule

`default_nettype wire

// ==== tb/icache_tb.sv ====
//----------------------------
// icache front end testbench
// random reads, direct mapped tag model
// in order response and FM request checks
//----------------------------
`timescale 1ns/10ps
`default_nettype none

`include "icache_params.svh"

module icache_tb
    import icache_pkg::*;
();

localparam int num_requests  = 400;
localparam int ready_timeout = 500;
localparam int drain_timeout = 2000;

logic        clk;
logic        reset;
logic        req_valid;
t_address    req_address;
t_reg_id     req_reg_id;
logic        ready;
logic        rsp_valid;
t_address    rsp_address;
t_word       rsp_data;
t_reg_id     rsp_reg_id;
logic        fm_rd_req_valid;
t_cl_address fm_rd_req_cl_address;
logic        fm_rd_rsp_valid;
t_cl_address fm_rd_rsp_cl_address;
t_cl         fm_rd_rsp_data;

// reference state
integer      seed;
t_address    exp_address_q[$];
t_reg_id     exp_reg_id_q [$];
t_cl_address miss_q       [$];          // lines the FM should see in order
t_cl         fetched      [t_cl_address]; // lines seen on the FM response
logic        model_valid  [`ICACHE_NUM_SETS];
t_tag        model_tag    [`ICACHE_NUM_SETS];
int          accepted;
int          responded;
int          fm_count;
int          miss_count;
int          wait_cycles;
logic        ready_seen;

icache_top      i_icache_top      (.*);
icache_fm_model i_icache_fm_model (.*);

always #5 clk = ~clk;

//----------------------------
// check helpers
//----------------------------
task automatic stop_on_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first failure");
endtask

task automatic check_value(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
        $display("error: %s is %0h, expected %0h", name, got, exp);
        stop_on_failure();
    end
endtask

task automatic verify_fm_request();
    t_cl_address exp_cl;
    fm_count++;
    if (miss_q.size() == 0) begin
        $display("FM read request %0d was issued without a predicted miss", fm_count);
        stop_on_failure();
    end else begin
        exp_cl = miss_q.pop_front();
        check_value("fm_rd_req_cl_address", fm_rd_req_cl_address, exp_cl);
    end
endtask

task automatic score_response();
    t_address     addr;
    t_reg_id      reg_id;
    t_cl_address  cl;
    t_word_offset offset;
    t_cl          line;
    if (exp_address_q.size() == 0) begin
        $display("a response arrived with no accepted request outstanding");
        stop_on_failure();
    end else begin
        addr   = exp_address_q.pop_front();
        reg_id = exp_reg_id_q.pop_front();
        cl     = addr[`ICACHE_ADDR_W-1 -: `ICACHE_CL_ADDR_W];
        offset = addr[`ICACHE_WORD_OFF_LSB +: `ICACHE_WORD_OFF_W];
        check_value("rsp_address", rsp_address, addr);
        check_value("rsp_reg_id", rsp_reg_id, reg_id);
        if (!fetched.exists(cl)) begin
            $display("response to address %0h, whose line never came back from FM", addr);
            stop_on_failure();
        end else begin
            line = fetched[cl];
            check_value("rsp_data", rsp_data, line[offset*`ICACHE_WORD_W +: `ICACHE_WORD_W]);
        end
        responded++;
    end
endtask

// drive one read on a rising edge and update the tag model
task automatic launch_request();
    t_set     set;
    t_tag     tag;
    t_address addr;
    t_reg_id  reg_id;
    set    = t_set'($unsigned($random(seed)) % 8);
    tag    = {2'($unsigned($random(seed)) % 3), 22'h15a5c3};
    addr   = {tag, set, t_word_offset'($random(seed)), 2'b00};
    reg_id = t_reg_id'($random(seed));
    req_valid   <= 1'b1;
    req_address <= addr;
    req_reg_id  <= reg_id;
    if (!model_valid[set] || (model_tag[set] != tag)) begin
        miss_count++;
        miss_q.push_back({tag, set});
    end
    model_valid[set] = 1'b1;
    model_tag[set]   = tag;                 // a conflict evicts the old line
    exp_address_q.push_back(addr);
    exp_reg_id_q.push_back(reg_id);
    accepted++;
endtask

//----------------------------
// monitor sampled mid cycle
//----------------------------
always @(negedge clk) begin
    if (!reset) begin
        if (fm_rd_rsp_valid)
            fetched[fm_rd_rsp_cl_address] = fm_rd_rsp_data;
        if (fm_rd_req_valid)
            verify_fm_request();
        if (rsp_valid)
            score_response();
    end
end

initial begin
    seed        = 32'h605;
    clk         = 1'b0;
    reset       = 1'b1;
    req_valid   = 1'b0;
    req_address = '0;
    req_reg_id  = '0;
    accepted    = 0;
    responded   = 0;
    fm_count    = 0;
    miss_count  = 0;
    for (int s = 0; s < `ICACHE_NUM_SETS; s++) begin
        model_valid[s] = 1'b0;
        model_tag[s]   = '0;
    end
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // quiet cycles right after reset
    repeat (4) begin
        @(negedge clk);
        check_value("ready", ready, 1);
        check_value("rsp_valid", rsp_valid, 0);
        check_value("fm_rd_req_valid", fm_rd_req_valid, 0);
    end

    wait_cycles = 0;
    while (accepted < num_requests) begin
        @(negedge clk);
        ready_seen = ready;
        @(posedge clk);
        if (ready_seen && ($unsigned($random(seed)) % 4 != 0))
            launch_request();
        else
            req_valid <= 1'b0;
        wait_cycles = ready_seen ? 0 : wait_cycles + 1;
        if (wait_cycles > ready_timeout) begin
            $display("ready stayed low for %0d cycles", wait_cycles);
            stop_on_failure();
        end
    end
    @(posedge clk);
    req_valid <= 1'b0;

    wait_cycles = 0;
    while (responded < accepted) begin
        @(posedge clk);
        wait_cycles++;
        if (wait_cycles > drain_timeout) begin
            $display("only %0d of %0d responses came back", responded, accepted);
            stop_on_failure();
        end
    end
    repeat (20) @(posedge clk);             // room for a stray response
    @(negedge clk);
    check_value("ready", ready, 1);
    check_value("FM read count", fm_count, miss_count);
    $display("%0d reads, %0d predicted misses, %0d FM reads", accepted, miss_count, fm_count);
    $display("SIMULATION PASSED");
    $finish;
end

endmodule

`default_nettype wire

// ==== icache.f ====
+incdir+logic
logic/icache_pkg.sv
logic/icache_req_decode.sv
logic/icache_tq.sv
logic/icache_lookup_pipe.sv
logic/icache_rsp_select.sv
logic/icache_top.sv
tb/icache_fm_model.sv
tb/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the icache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --timescale 1ns/10ps --top-module icache_tb \
    -f icache.f -o icache_sim && ./obj_dir/icache_sim || exit 1
